// ==== uart_dbg_params.svh ====
`ifndef UART_DBG_PARAMS_SVH
`define UART_DBG_PARAMS_SVH

//////////////////////////////////////////////////
// Engine memory
//////////////////////////////////////////////////

// Byte count, power of two so addresses wrap
`define DBG_MEM_BYTES 1024

//////////////////////////////////////////////////
// Command header
//////////////////////////////////////////////////

// Little-endian field sizes in bytes
`define DBG_ADDR_BYTES 2
`define DBG_LEN_BYTES 2

//////////////////////////////////////////////////
// Serial link
//////////////////////////////////////////////////

`define DBG_DIV_WIDTH 16
`define DBG_DIV_RESET 16

`endif

// ==== uart_dbg_proto_pkg.sv ====
`default_nettype none

`include "uart_dbg_params.svh"

package uart_dbg_proto_pkg;

  // Protocol bytes on the wire
  typedef enum logic [7:0] {
    OP_EOT   = 8'h04,
    OP_ACK   = 8'h06,
    OP_READ  = 8'h11,
    OP_WRITE = 8'h12
  } dbg_opcode_e;

  // Command engine states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HDR,
    ST_ACK,
    ST_READ,
    ST_WRITE,
    ST_EOT
  } dbg_state_e;

  typedef logic [8*`DBG_ADDR_BYTES-1:0] dbg_addr_t;
  typedef logic [8*`DBG_LEN_BYTES-1:0]  dbg_len_t;

endpackage

`default_nettype wire

// ==== uart_dbg_link_pkg.sv ====
`default_nettype none

`include "uart_dbg_params.svh"

package uart_dbg_link_pkg;

  typedef logic [`DBG_DIV_WIDTH-1:0] dbg_div_t;

  // Clock cycles per bit in div
  typedef struct packed {
    logic     enable;
    dbg_div_t div;
  } dbg_cfg_t;

  // One received frame
  typedef struct packed {
    logic [7:0] data;
    logic       frame_err;
  } dbg_rx_byte_t;

endpackage

`default_nettype wire

// ==== uart_dbg_cfg_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_dbg_params.svh"

module uart_dbg_cfg_regs (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  logic                        cfg_req_i,
  input  uart_dbg_link_pkg::dbg_cfg_t cfg_wdata_i,
  output logic                        cfg_ack_o,
  output uart_dbg_link_pkg::dbg_cfg_t cfg_o
);

  uart_dbg_link_pkg::dbg_cfg_t cfg_q;
  logic                        ack_q;

  //////////////////////////////////////////////////
  // Four-phase slave
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q.enable <= 1'b0;
      cfg_q.div    <= uart_dbg_link_pkg::dbg_div_t'(`DBG_DIV_RESET);
      ack_q        <= 1'b0;
    end else begin
      if (cfg_req_i && !ack_q) begin
        // New request, store and acknowledge
        cfg_q <= cfg_wdata_i;
        ack_q <= 1'b1;
      end else if (!cfg_req_i && ack_q) begin
        // Host released req, close the handshake
        ack_q <= 1'b0;
      end
    end
  end

  assign cfg_ack_o = ack_q;

  // Steers rx and tx continuously
  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// ==== uart_dbg_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_dbg_rx (
  input  logic                            clk,
  input  logic                            arst_n_i,
  input  uart_dbg_link_pkg::dbg_cfg_t     cfg_i,
  input  logic                            rxd_i,
  output logic                            rx_valid_o,
  output uart_dbg_link_pkg::dbg_rx_byte_t rx_byte_o
);

  typedef enum logic {
    RX_IDLE,
    RX_FRAME
  } rx_state_e;

  rx_state_e                   state_q;
  logic [2:0]                  sync_q;
  uart_dbg_link_pkg::dbg_div_t div_q;
  uart_dbg_link_pkg::dbg_div_t cnt_q;
  logic [3:0]                  bit_q;
  logic [7:0]                  shift_q;
  logic                        ferr_q;
  logic                        sample;

  // Mid-bit strobe, bit 0 is start and bit 9 is stop
  assign sample = (state_q == RX_FRAME) && (cnt_q == (div_q >> 1));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q     <= '1;
      state_q    <= RX_IDLE;
      div_q      <= '0;
      cnt_q      <= '0;
      bit_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      sync_q     <= {sync_q[1:0], rxd_i};
      rx_valid_o <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          // Falling start edge, divisor frozen for this frame
          if (cfg_i.enable && sync_q[2] && !sync_q[1]) begin
            state_q <= RX_FRAME;
            div_q   <= cfg_i.div;
            cnt_q   <= '0;
            bit_q   <= '0;
          end
        end
        default: begin
          if (cnt_q == div_q - 1'b1) begin
            cnt_q <= '0;
            bit_q <= bit_q + 1'b1;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
          if (sample) begin
            if (bit_q == 4'd0 && sync_q[1]) begin
              // Glitch, not a real start bit
              state_q <= RX_IDLE;
            end else if (bit_q == 4'd9) begin
              state_q    <= RX_IDLE;
              rx_valid_o <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (sample && bit_q >= 4'd1 && bit_q <= 4'd8) begin
      shift_q <= {sync_q[1], shift_q[7:1]};
    end
    if (sample && bit_q == 4'd9) begin
      ferr_q <= !sync_q[1];
    end
  end

  assign rx_byte_o.data      = shift_q;
  assign rx_byte_o.frame_err = ferr_q;

endmodule

`default_nettype wire

// ==== uart_dbg_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_dbg_tx (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  uart_dbg_link_pkg::dbg_cfg_t cfg_i,
  input  logic                        tx_req_i,
  input  logic [7:0]                  tx_byte_i,
  output logic                        tx_ack_o,
  output logic                        txd_o
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_FRAME,
    TX_DONE
  } tx_state_e;

  tx_state_e                   state_q;
  uart_dbg_link_pkg::dbg_div_t div_q;
  uart_dbg_link_pkg::dbg_div_t cnt_q;
  logic [3:0]                  bit_q;
  logic [9:0]                  frame_q;
  logic                        bit_end;

  assign bit_end = (cnt_q == div_q - 1'b1);

  // Line idles high once the frame has shifted out
  assign txd_o = frame_q[0];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= TX_IDLE;
      div_q    <= '0;
      cnt_q    <= '0;
      bit_q    <= '0;
      frame_q  <= '1;
      tx_ack_o <= 1'b0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (tx_req_i) begin
            // Stop, data, start
            frame_q  <= {1'b1, tx_byte_i, 1'b0};
            div_q    <= cfg_i.div;
            cnt_q    <= '0;
            bit_q    <= '0;
            tx_ack_o <= 1'b1;
            state_q  <= TX_FRAME;
          end
        end
        TX_FRAME: begin
          if (bit_end) begin
            cnt_q   <= '0;
            frame_q <= {1'b1, frame_q[9:1]};
            if (bit_q == 4'd9) begin
              state_q <= TX_DONE;
            end else begin
              bit_q <= bit_q + 1'b1;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          // Hold ack until the stop bit is over and req is gone
          if (!tx_req_i) begin
            tx_ack_o <= 1'b0;
            state_q  <= TX_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== uart_dbg_cmd_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_dbg_params.svh"

module uart_dbg_cmd_engine (
  input  logic                            clk,
  input  logic                            arst_n_i,
  input  logic                            rx_valid_i,
  input  uart_dbg_link_pkg::dbg_rx_byte_t rx_byte_i,
  output logic                            tx_req_o,
  output logic [7:0]                      tx_byte_o,
  input  logic                            tx_ack_i
);

  localparam int HDR_BYTES = `DBG_ADDR_BYTES + `DBG_LEN_BYTES;
  localparam int MEM_AW    = $clog2(`DBG_MEM_BYTES);

  uart_dbg_proto_pkg::dbg_state_e  state_q;
  uart_dbg_proto_pkg::dbg_opcode_e op_q;
  logic [$clog2(HDR_BYTES+1)-1:0]  hdr_cnt_q;
  uart_dbg_proto_pkg::dbg_addr_t   addr_q;
  uart_dbg_proto_pkg::dbg_len_t    len_q;
  logic                            tx_pend_q;
  logic [7:0]                      mem [`DBG_MEM_BYTES];
  logic [MEM_AW-1:0]               mem_idx;
  logic                            rx_ok;
  logic                            sending;
  logic [7:0]                      send_byte;
  logic                            tx_fin;

  // Addresses wrap modulo the memory size
  assign mem_idx = addr_q[MEM_AW-1:0];
  assign rx_ok   = rx_valid_i && !rx_byte_i.frame_err;

  // Byte handed over and transmitter released again
  assign tx_fin = tx_pend_q && !tx_req_o && !tx_ack_i;

  always_comb begin
    sending   = 1'b1;
    send_byte = uart_dbg_proto_pkg::OP_ACK;
    case (state_q)
      uart_dbg_proto_pkg::ST_READ: send_byte = mem[mem_idx];
      uart_dbg_proto_pkg::ST_EOT:  send_byte = uart_dbg_proto_pkg::OP_EOT;
      uart_dbg_proto_pkg::ST_ACK:  send_byte = uart_dbg_proto_pkg::OP_ACK;
      default:                     sending   = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Command FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= uart_dbg_proto_pkg::ST_IDLE;
      op_q      <= uart_dbg_proto_pkg::OP_ACK;
      hdr_cnt_q <= '0;
      addr_q    <= '0;
      len_q     <= '0;
      tx_req_o  <= 1'b0;
      tx_pend_q <= 1'b0;
    end else begin
      // Four-phase master towards tx
      if (sending && !tx_pend_q) begin
        tx_req_o  <= 1'b1;
        tx_pend_q <= 1'b1;
      end else if (tx_req_o && tx_ack_i) begin
        tx_req_o <= 1'b0;
      end else if (tx_fin) begin
        tx_pend_q <= 1'b0;
      end

      case (state_q)
        uart_dbg_proto_pkg::ST_IDLE: begin
          if (rx_ok) begin
            case (uart_dbg_proto_pkg::dbg_opcode_e'(rx_byte_i.data))
              uart_dbg_proto_pkg::OP_ACK: begin
                op_q    <= uart_dbg_proto_pkg::OP_ACK;
                state_q <= uart_dbg_proto_pkg::ST_ACK;
              end
              uart_dbg_proto_pkg::OP_READ, uart_dbg_proto_pkg::OP_WRITE: begin
                op_q      <= uart_dbg_proto_pkg::dbg_opcode_e'(rx_byte_i.data);
                hdr_cnt_q <= '0;
                state_q   <= uart_dbg_proto_pkg::ST_HDR;
              end
              // Anything else is dropped
              default: ;
            endcase
          end
        end
        uart_dbg_proto_pkg::ST_HDR: begin
          if (rx_ok) begin
            // Little endian, first byte ends up lowest
            if (hdr_cnt_q < `DBG_ADDR_BYTES) begin
              addr_q <= {rx_byte_i.data, addr_q[$bits(addr_q)-1:8]};
            end else begin
              len_q <= {rx_byte_i.data, len_q[$bits(len_q)-1:8]};
            end
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
            if (hdr_cnt_q == HDR_BYTES - 1) begin
              state_q <= uart_dbg_proto_pkg::ST_ACK;
            end
          end
        end
        uart_dbg_proto_pkg::ST_ACK: begin
          if (tx_fin) begin
            if (op_q == uart_dbg_proto_pkg::OP_ACK) begin
              state_q <= uart_dbg_proto_pkg::ST_IDLE;
            end else if (len_q == '0) begin
              state_q <= uart_dbg_proto_pkg::ST_EOT;
            end else if (op_q == uart_dbg_proto_pkg::OP_READ) begin
              state_q <= uart_dbg_proto_pkg::ST_READ;
            end else begin
              state_q <= uart_dbg_proto_pkg::ST_WRITE;
            end
          end
        end
        uart_dbg_proto_pkg::ST_READ: begin
          if (tx_fin) begin
            addr_q <= addr_q + 1'b1;
            len_q  <= len_q - 1'b1;
            if (len_q == 1) begin
              state_q <= uart_dbg_proto_pkg::ST_EOT;
            end
          end
        end
        uart_dbg_proto_pkg::ST_WRITE: begin
          if (rx_ok) begin
            addr_q <= addr_q + 1'b1;
            len_q  <= len_q - 1'b1;
            if (len_q == 1) begin
              state_q <= uart_dbg_proto_pkg::ST_EOT;
            end
          end
        end
        default: begin
          if (tx_fin) begin
            state_q <= uart_dbg_proto_pkg::ST_IDLE;
          end
        end
      endcase
    end
  end

  // Byte held stable for the whole handshake
  always_ff @(posedge clk) begin
    if (sending && !tx_pend_q) begin
      tx_byte_o <= send_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == uart_dbg_proto_pkg::ST_WRITE && rx_ok) begin
      mem[mem_idx] <= rx_byte_i.data;
    end
  end

endmodule

`default_nettype wire

// ==== uart_dbg_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_dbg_top (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  logic                        cfg_req_i,
  input  uart_dbg_link_pkg::dbg_cfg_t cfg_wdata_i,
  output logic                        cfg_ack_o,
  input  logic                        uart_rx_i,
  output logic                        uart_tx_o
);

  uart_dbg_link_pkg::dbg_cfg_t     cfg;
  logic                            rx_valid;
  uart_dbg_link_pkg::dbg_rx_byte_t rx_byte;
  logic                            tx_req;
  logic [7:0]                      tx_byte;
  logic                            tx_ack;

  uart_dbg_cfg_regs i_cfg_regs (
    .clk         ( clk         ),
    .arst_n_i    ( arst_n_i    ),
    .cfg_req_i   ( cfg_req_i   ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_ack_o   ( cfg_ack_o   ),
    .cfg_o       ( cfg         )
  );

  uart_dbg_rx i_rx (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .cfg_i      ( cfg       ),
    .rxd_i      ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_byte_o  ( rx_byte   )
  );

  // Command decode and memory
  uart_dbg_cmd_engine i_cmd_engine (
    .clk        ( clk      ),
    .arst_n_i   ( arst_n_i ),
    .rx_valid_i ( rx_valid ),
    .rx_byte_i  ( rx_byte  ),
    .tx_req_o   ( tx_req   ),
    .tx_byte_o  ( tx_byte  ),
    .tx_ack_i   ( tx_ack   )
  );

  uart_dbg_tx i_tx (
    .clk       ( clk       ),
    .arst_n_i  ( arst_n_i  ),
    .cfg_i     ( cfg       ),
    .tx_req_i  ( tx_req    ),
    .tx_byte_i ( tx_byte   ),
    .tx_ack_o  ( tx_ack    ),
    .txd_o     ( uart_tx_o )
  );

endmodule

`default_nettype wire

// ==== tb_uart_dbg_uart.svh ====
`ifndef TB_UART_DBG_UART_SVH
`define TB_UART_DBG_UART_SVH

//////////////////////////////////////////////////
// Random data
//////////////////////////////////////////////////

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

//////////////////////////////////////////////////
// Serial line
//////////////////////////////////////////////////

// One 8N1 frame at the current divisor
task send_uart_byte(input logic [7:0] b);
  logic [9:0] frame;
  frame = {1'b1, b, 1'b0};
  for (int i = 0; i < 10; i++) begin
    @(negedge clk);
    uart_rx = frame[i];
    repeat (div_cur - 1) @(negedge clk);
  end
endtask

// Entered with the start bit already seen low
task recv_uart_frame(output logic [7:0] b);
  repeat (div_cur / 2) @(negedge clk);
  assert (uart_tx === 1'b0) else begin
    $display("error %0t: start bit not low at its middle", $time);
    err_cnt++;
  end
  // LSB first
  for (int i = 0; i < 8; i++) begin
    repeat (div_cur) @(negedge clk);
    b[i] = uart_tx;
  end
  repeat (div_cur) @(negedge clk);
  assert (uart_tx === 1'b1) else begin
    $display("error %0t: stop bit not high at its middle", $time);
    err_cnt++;
  end
endtask

//////////////////////////////////////////////////
// Configuration port
//////////////////////////////////////////////////

task write_cfg(input logic en, input int div);
  int t;
  @(negedge clk);
  cfg_wdata.enable = en;
  cfg_wdata.div    = uart_dbg_link_pkg::dbg_div_t'(div);
  cfg_req          = 1'b1;
  t = 0;
  while (cfg_ack !== 1'b1 && t < CFG_TIMEOUT) begin
    @(negedge clk);
    t++;
  end
  if (cfg_ack !== 1'b1) begin
    $display("configuration request got no acknowledge before the timeout");
    err_cnt++;
  end
  cfg_req = 1'b0;
  t = 0;
  while (cfg_ack !== 1'b0 && t < CFG_TIMEOUT) begin
    @(negedge clk);
    t++;
  end
  if (cfg_ack !== 1'b0) begin
    $display("configuration acknowledge stayed high after the request dropped");
    err_cnt++;
  end
  // Later frames run at the new bit period
  div_cur = div;
endtask

`endif

// ==== tb_uart_dbg.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_dbg_params.svh"

module tb_uart_dbg;

  localparam int          SILENCE_BITS = 20;
  localparam int          GUARD_CYCLES = 200000;
  localparam int          CFG_TIMEOUT  = 50;
  localparam int          BLOCK_BYTES  = 16;
  localparam int          WRAP_ADDR    = 1020;
  localparam logic [31:0] SEED         = 32'h952;

  logic                        clk = 1'b0;
  logic                        arst_n;
  logic                        cfg_req;
  uart_dbg_link_pkg::dbg_cfg_t cfg_wdata;
  logic                        cfg_ack;
  logic                        uart_rx;
  logic                        uart_tx;

  int          div_cur;
  int          err_cnt  = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  logic [31:0] rng;
  logic        send_done;
  logic [7:0]  cmd_q[$];
  logic [7:0]  exp_q[$];
  logic [7:0]  got_q[$];
  // Reference copy of the DUT memory
  logic [7:0]  model_mem [`DBG_MEM_BYTES];

  always #5 clk = ~clk;

  uart_dbg_top dut (
    .clk         ( clk       ),
    .arst_n_i    ( arst_n    ),
    .cfg_req_i   ( cfg_req   ),
    .cfg_wdata_i ( cfg_wdata ),
    .cfg_ack_o   ( cfg_ack   ),
    .uart_rx_i   ( uart_rx   ),
    .uart_tx_o   ( uart_tx   )
  );

  // Ack may only rise on a request seen high
  ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(cfg_ack) |-> $past(cfg_req))
  else begin
    $display("error %0t: cfg_ack_o rose without a request", $time);
    err_cnt++;
  end

  `include "tb_uart_dbg_uart.svh"

  //////////////////////////////////////////////////
  // Command helpers
  //////////////////////////////////////////////////

  task push_header(input logic [7:0] op, input uart_dbg_proto_pkg::dbg_addr_t addr,
                   input uart_dbg_proto_pkg::dbg_len_t len);
    cmd_q.push_back(op);
    cmd_q.push_back(addr[7:0]);
    cmd_q.push_back(addr[15:8]);
    cmd_q.push_back(len[7:0]);
    cmd_q.push_back(len[15:8]);
  endtask

  // Send cmd_q and collect replies until the line stays quiet
  task run_transfer();
    int         idle;
    int         guard;
    logic [7:0] b;
    send_done = 1'b0;
    fork
      begin
        for (int i = 0; i < cmd_q.size(); i++) begin
          send_uart_byte(cmd_q[i]);
        end
        send_done = 1'b1;
      end
      begin
        idle  = 0;
        guard = 0;
        while (idle < SILENCE_BITS * div_cur && guard < GUARD_CYCLES) begin
          @(negedge clk);
          guard++;
          if (uart_tx === 1'b0) begin
            recv_uart_frame(b);
            got_q.push_back(b);
            guard += 10 * div_cur;
            idle = 0;
          end else if (send_done) begin
            idle++;
          end
        end
        if (guard >= GUARD_CYCLES) begin
          $display("the serial line did not go quiet before the timeout");
          err_cnt++;
        end
      end
    join
    cmd_q.delete();
  endtask

  task check_reply(input string what);
    assert (got_q.size() == exp_q.size()) else begin
      $display("error %0t: %s returned %0d bytes, expected %0d", $time, what,
               got_q.size(), exp_q.size());
      err_cnt++;
    end
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      assert (got_q[i] === exp_q[i]) else begin
        $display("error %0t: %s byte %0d is %h, expected %h", $time, what, i,
                 got_q[i], exp_q[i]);
        err_cnt++;
      end
    end
    got_q.delete();
    exp_q.delete();
  endtask

  // Data must wait for the ACK, or the engine drops it
  task write_block(input uart_dbg_proto_pkg::dbg_addr_t addr, input int len,
                   input string what);
    push_header(uart_dbg_proto_pkg::OP_WRITE, addr, uart_dbg_proto_pkg::dbg_len_t'(len));
    exp_q.push_back(uart_dbg_proto_pkg::OP_ACK);
    run_transfer();
    for (int i = 0; i < len; i++) begin
      rng = xorshift32(rng);
      cmd_q.push_back(rng[7:0]);
      model_mem[(int'(addr) + i) % `DBG_MEM_BYTES] = rng[7:0];
    end
    exp_q.push_back(uart_dbg_proto_pkg::OP_EOT);
    run_transfer();
    check_reply(what);
  endtask

  task read_block(input uart_dbg_proto_pkg::dbg_addr_t addr, input int len,
                  input string what);
    push_header(uart_dbg_proto_pkg::OP_READ, addr, uart_dbg_proto_pkg::dbg_len_t'(len));
    exp_q.push_back(uart_dbg_proto_pkg::OP_ACK);
    for (int i = 0; i < len; i++) begin
      exp_q.push_back(model_mem[(int'(addr) + i) % `DBG_MEM_BYTES]);
    end
    exp_q.push_back(uart_dbg_proto_pkg::OP_EOT);
    run_transfer();
    check_reply(what);
  endtask

  task check_idle_outputs();
    assert (uart_tx === 1'b1 && cfg_ack === 1'b0) else begin
      $display("error %0t: uart_tx_o %b cfg_ack_o %b, expected 1 and 0", $time,
               uart_tx, cfg_ack);
      err_cnt++;
    end
  endtask

  task end_test(input string name, input int mark);
    if (err_cnt == mark) begin
      pass_cnt++;
      $display("test %s passed", name);
    end else begin
      fail_cnt++;
      $display("test %s failed", name);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    int                            mark;
    uart_dbg_proto_pkg::dbg_addr_t base;
    arst_n    = 1'b0;
    cfg_req   = 1'b0;
    cfg_wdata = '0;
    uart_rx   = 1'b1;
    div_cur   = `DBG_DIV_RESET;
    rng       = SEED;
    send_done = 1'b0;

    mark = err_cnt;
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      check_idle_outputs();
    end
    arst_n = 1'b1;
    @(negedge clk);
    check_idle_outputs();
    // Enable resets low, so no answer yet
    cmd_q.push_back(uart_dbg_proto_pkg::OP_ACK);
    run_transfer();
    check_reply("challenge while disabled");
    write_cfg(1'b1, 8);
    end_test("reset and configuration", mark);

    mark = err_cnt;
    cmd_q.push_back(uart_dbg_proto_pkg::OP_ACK);
    exp_q.push_back(uart_dbg_proto_pkg::OP_ACK);
    run_transfer();
    check_reply("ack challenge");
    end_test("ack challenge", mark);

    mark = err_cnt;
    rng  = xorshift32(rng);
    base = rng[15:0];
    write_block(base, BLOCK_BYTES, "block write");
    read_block(base, BLOCK_BYTES, "block read");
    end_test("write then read back", mark);

    mark = err_cnt;
    write_block(uart_dbg_proto_pkg::dbg_addr_t'(WRAP_ADDR), 8, "wrapping write");
    read_block(16'h0000, 4, "read at address 0");
    // Same bytes through an alias above the memory size
    read_block(16'h0400, 4, "aliased read");
    end_test("address wrap", mark);

    mark = err_cnt;
    rng  = xorshift32(rng);
    read_block(rng[15:0], 0, "zero length read");
    cmd_q.push_back(8'h55);
    run_transfer();
    check_reply("unknown byte");
    cmd_q.push_back(uart_dbg_proto_pkg::OP_ACK);
    exp_q.push_back(uart_dbg_proto_pkg::OP_ACK);
    run_transfer();
    check_reply("challenge after unknown byte");
    end_test("zero length and unknown opcode", mark);

    mark = err_cnt;
    write_cfg(1'b1, 5);
    read_block(base, BLOCK_BYTES, "read at divisor 5");
    end_test("divisor change", mark);

    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
uart_dbg_proto_pkg.sv
uart_dbg_link_pkg.sv
uart_dbg_cfg_regs.sv
uart_dbg_rx.sv
uart_dbg_tx.sv
uart_dbg_cmd_engine.sv
uart_dbg_top.sv
tb_uart_dbg.sv

// ==== Bender.yml ====
package:
  name: uart_dbg

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - uart_dbg_proto_pkg.sv
      - uart_dbg_link_pkg.sv
      - uart_dbg_cfg_regs.sv
      - uart_dbg_rx.sv
      - uart_dbg_tx.sv
      - uart_dbg_cmd_engine.sv
      - uart_dbg_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_uart_dbg.sv
